// File: logic/nibble_pkg.sv
// Nibble-serial core definitions
package nibble_pkg;

    typedef logic [3:0]  nibble_t;    // One data slice
    typedef logic [31:0] word_t;
    typedef logic [27:0] addr_t;      // Bits 31 to 4 of a computed address
    typedef logic [3:0]  reg_addr_t;  // RV32E register index
    typedef logic [2:0]  count_t;     // Sub-cycle counter
    typedef logic [3:0]  alu_op_t;    // {sub/compare, funct3}

    localparam int     NUM_REGS   = 16;
    localparam count_t LAST_COUNT = 3'd7;

    // Major opcodes of the kept instructions
    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_AUIPC   = 7'b0010111;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_JALR    = 7'b1100111;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OP_ALU_REG = 7'b0110011;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: logic/decoded_if.sv
// Decoded instruction bundle
`timescale 1ns/1ps

interface decoded_if import nibble_pkg::*; ();

    nibble_t   imm;         // Immediate slice for the current counter
    alu_op_t   alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      is_alu_imm;
    logic      is_alu_reg;
    logic      is_lui;
    logic      is_auipc;
    logic      is_jal;
    logic      is_jalr;
    logic      is_branch;
    logic      is_store;
    logic      branch_inv;  // BNE, BGE, BGEU take on a false compare

    modport issue (
        output imm, alu_op, rs1, rs2, rd,
        output is_alu_imm, is_alu_reg, is_lui, is_auipc,
        output is_jal, is_jalr, is_branch, is_store, branch_inv
    );

    modport core (
        input imm, alu_op, rs1, rs2, rd,
        input is_alu_imm, is_alu_reg, is_lui, is_auipc,
        input is_jal, is_jalr, is_branch, is_store, branch_inv
    );

endinterface

// File: logic/nibble_regfile.sv
// Nibble-rotating register file
`timescale 1ns/1ps

module nibble_regfile import nibble_pkg::*; (
    input  logic      clk,
    input  logic      wr_en,
    input  count_t    counter,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  nibble_t   data_rd,
    output nibble_t   data_rs1,
    output nibble_t   data_rs2
);

    word_t regs [1:NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (wr_en && rd == reg_addr_t'(i)) begin
                regs[i] <= {data_rd, regs[i][31:4]};  // New slice enters at the top
            end else begin
                regs[i] <= {regs[i][3:0], regs[i][31:4]};
            end
        end
    end

    // x0 reads zero
    always_comb begin
        data_rs1 = '0;
        data_rs2 = '0;
        if (rs1 != '0)
            data_rs1 = regs[rs1][3:0];
        if (rs2 != '0)
            data_rs2 = regs[rs2][3:0];
    end

endmodule

// File: logic/nibble_alu.sv
// Four-bit ALU slice
`timescale 1ns/1ps

module nibble_alu import nibble_pkg::*; (
    input  alu_op_t op,
    input  nibble_t a,
    input  nibble_t b,
    input  logic    cy_in,
    input  logic    cmp_in,
    output nibble_t result,
    output logic    cy_out,
    output logic    cmp_out
);

    logic       sub;
    logic [4:0] sum;
    logic       lt;

    assign sub    = op[3] || op[1];  // Subtract for SUB, SLT/SLTU and compares
    assign sum    = {1'b0, a} + {1'b0, sub ? ~b : b} + {4'b0000, cy_in};
    assign cy_out = sum[4];

    always_comb begin
        case (op[2:0])
            3'b100:  result = a ^ b;
            3'b110:  result = a | b;
            3'b111:  result = a & b;
            default: result = sum[3:0];
        endcase
    end

    // Sign bits only count in the top slice, which is the last one evaluated
    assign lt = (!op[0] && (a[3] ^ b[3])) ? a[3] : !cy_out;

    always_comb begin
        case (op[2:1])
            2'b00:   cmp_out = cmp_in && (a == b);  // Equality chain
            2'b01:   cmp_out = lt;
            default: cmp_out = cmp_in;
        endcase
    end

endmodule

// File: logic/issue_stage.sv
// Instruction issue and decode
`timescale 1ns/1ps

module issue_stage import nibble_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  word_t   instr,
    input  logic    instr_complete,
    input  logic    branch,
    input  addr_t   addr_out,
    decoded_if.issue dec,
    output count_t  counter,
    output nibble_t pc_nib,
    output nibble_t next_pc_nib,
    output word_t   pc
);

    word_t       instr_reg;
    word_t       next_pc;
    word_t       imm_word;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  slice_lsb;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter   <= '0;
            instr_reg <= NOP_INSTR;
            pc        <= '0;
        end else begin
            counter <= counter + 3'd1;  // Wraps every pass
            if (instr_complete) begin
                instr_reg <= instr;
                pc        <= branch ? {addr_out, 4'b0000} : next_pc;
            end
        end
    end

    assign opcode    = instr_reg[6:0];
    assign funct3    = instr_reg[14:12];
    assign next_pc   = pc + 32'd4;
    assign slice_lsb = {counter, 2'b00};

    // RV32E only needs four bits of each register field
    assign dec.rd  = instr_reg[10:7];
    assign dec.rs1 = instr_reg[18:15];
    assign dec.rs2 = instr_reg[23:20];

    assign dec.is_alu_imm = opcode == OP_ALU_IMM;
    assign dec.is_alu_reg = opcode == OP_ALU_REG;
    assign dec.is_lui     = opcode == OP_LUI;
    assign dec.is_auipc   = opcode == OP_AUIPC;
    assign dec.is_jal     = opcode == OP_JAL;
    assign dec.is_jalr    = opcode == OP_JALR;
    assign dec.is_branch  = opcode == OP_BRANCH;
    assign dec.is_store   = opcode == OP_STORE;

    always_comb begin
        dec.alu_op     = '0;  // Plain add for address and pc sums
        dec.branch_inv = 1'b0;
        case (opcode)
            OP_ALU_REG: dec.alu_op = {instr_reg[30] && funct3 == 3'b000, funct3};
            OP_ALU_IMM: dec.alu_op = {1'b0, funct3};
            OP_BRANCH: begin
                // Map onto equality or the slt/sltu compare codes
                dec.alu_op     = funct3[2] ? {3'b101, funct3[1]} : 4'b1000;
                dec.branch_inv = funct3[0];
            end
            default: dec.alu_op = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_STORE:
                imm_word = {{20{instr_reg[31]}}, instr_reg[31:25], instr_reg[11:7]};
            OP_BRANCH:
                imm_word = {{20{instr_reg[31]}}, instr_reg[7], instr_reg[30:25],
                            instr_reg[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm_word = {instr_reg[31:12], 12'h000};
            OP_JAL:
                imm_word = {{12{instr_reg[31]}}, instr_reg[19:12], instr_reg[20],
                            instr_reg[30:21], 1'b0};
            default:
                imm_word = {{20{instr_reg[31]}}, instr_reg[31:20]};  // I-type
        endcase
    end

    assign dec.imm     = imm_word[slice_lsb +: 4];
    assign pc_nib      = pc[slice_lsb +: 4];
    assign next_pc_nib = next_pc[slice_lsb +: 4];

endmodule

// File: logic/exec_core.sv
// Nibble-serial execute core
`timescale 1ns/1ps

module exec_core import nibble_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    decoded_if.core dec,
    input  count_t  counter,
    input  nibble_t pc_nib,
    input  nibble_t next_pc_nib,
    output nibble_t data_out,
    output addr_t   addr_out,
    output logic    address_ready,
    output logic    mem_write,
    output logic    instr_complete,
    output logic    branch
);

    nibble_t data_rs1;
    nibble_t data_rs2;
    nibble_t data_rd;
    logic    wr_en;

    logic    cycle;  // Pass index, two passes at most
    logic    last_count;
    logic    is_slt;
    logic    take_branch;

    alu_op_t alu_op_in;
    nibble_t alu_a;
    nibble_t alu_b;
    nibble_t alu_out;
    logic    cy;
    logic    cmp;
    logic    cy_in;
    logic    cmp_in;
    logic    cy_out;
    logic    cmp_out;

    word_t   tmp_data;

    nibble_regfile u_regfile (
        .clk      (clk),
        .wr_en    (wr_en),
        .counter  (counter),
        .rs1      (dec.rs1),
        .rs2      (dec.rs2),
        .rd       (dec.rd),
        .data_rd  (data_rd),
        .data_rs1 (data_rs1),
        .data_rs2 (data_rs2)
    );

    assign last_count = counter == LAST_COUNT;
    assign is_slt     = (dec.is_alu_imm || dec.is_alu_reg) && dec.alu_op[2:1] == 2'b01;

    // Second branch pass computes pc + offset
    assign alu_op_in = (dec.is_branch && cycle) ? alu_op_t'(0) : dec.alu_op;
    assign alu_a     = (dec.is_auipc || dec.is_jal || (dec.is_branch && cycle)) ?
                       pc_nib : data_rs1;
    assign alu_b     = (dec.is_alu_reg || (dec.is_branch && !cycle)) ? data_rs2 : dec.imm;
    assign cy_in     = (counter == '0) ? (alu_op_in[1] || alu_op_in[3]) : cy;
    assign cmp_in    = (counter == '0) ? 1'b1 : cmp;

    nibble_alu u_alu (
        .op      (alu_op_in),
        .a       (alu_a),
        .b       (alu_b),
        .cy_in   (cy_in),
        .cmp_in  (cmp_in),
        .result  (alu_out),
        .cy_out  (cy_out),
        .cmp_out (cmp_out)
    );

    always_ff @(posedge clk) begin
        cy  <= cy_out;
        cmp <= cmp_out;  // Holds the final compare into the next pass
    end

    always_comb begin
        wr_en   = 1'b0;
        data_rd = alu_out;
        if (dec.is_alu_imm || dec.is_alu_reg) begin
            if (is_slt) begin
                wr_en   = cycle;
                data_rd = (counter == '0) ? {3'b000, cmp} : 4'b0000;
            end else begin
                wr_en = 1'b1;
            end
        end else if (dec.is_auipc) begin
            wr_en = 1'b1;
        end else if (dec.is_lui) begin
            wr_en   = 1'b1;
            data_rd = dec.imm;
        end else if (dec.is_jal || dec.is_jalr) begin
            wr_en   = 1'b1;  // Link address
            data_rd = next_pc_nib;
        end
    end

    assign take_branch = cmp_out ^ dec.branch_inv;

    always_comb begin
        instr_complete = 1'b0;
        if (last_count) begin
            if (dec.is_alu_imm || dec.is_alu_reg)
                instr_complete = cycle == is_slt;
            else if (dec.is_lui || dec.is_auipc || dec.is_jal || dec.is_jalr || dec.is_store)
                instr_complete = 1'b1;
            else if (dec.is_branch)
                instr_complete = cycle || !take_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle <= 1'b0;
        end else if (last_count) begin
            cycle <= !instr_complete;
        end
    end

    assign branch = last_count && ((!cycle && (dec.is_jal || dec.is_jalr)) ||
                                   (cycle && dec.is_branch));

    // Slices 1 to 6 are held here, the top slice comes straight from the ALU
    always_ff @(posedge clk) begin
        tmp_data <= {alu_out, tmp_data[31:4]};
    end

    assign addr_out      = {alu_out, tmp_data[31:8]};
    assign address_ready = last_count && !cycle && dec.is_store;
    assign mem_write     = dec.is_store && !cycle;
    assign data_out      = data_rs2;

endmodule

// File: logic/serial_cpu_top.sv
// Serial RISC-V CPU top
`timescale 1ns/1ps

module serial_cpu_top import nibble_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  word_t   instr,
    output word_t   pc,
    output nibble_t data_out,
    output addr_t   addr_out,
    output logic    address_ready,
    output logic    mem_write,
    output logic    instr_complete,
    output logic    branch
);

    count_t  counter;
    nibble_t pc_nib;
    nibble_t next_pc_nib;

    decoded_if dec ();

    issue_stage u_issue (
        .clk            (clk),
        .rstn           (rstn),
        .instr          (instr),
        .instr_complete (instr_complete),
        .branch         (branch),
        .addr_out       (addr_out),
        .dec            (dec.issue),
        .counter        (counter),
        .pc_nib         (pc_nib),
        .next_pc_nib    (next_pc_nib),
        .pc             (pc)
    );

    exec_core u_core (
        .clk            (clk),
        .rstn           (rstn),
        .dec            (dec.core),
        .counter        (counter),
        .pc_nib         (pc_nib),
        .next_pc_nib    (next_pc_nib),
        .data_out       (data_out),
        .addr_out       (addr_out),
        .address_ready  (address_ready),
        .mem_write      (mem_write),
        .instr_complete (instr_complete),
        .branch         (branch)
    );

endmodule

// File: bench/tb_clock.sv
// Clock and reset source
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;
    end

endmodule

// File: bench/serial_cpu_checker.sv
// Pulse timing checks
`timescale 1ns/1ps

module serial_cpu_checker import nibble_pkg::*; (
    input logic   clk,
    input logic   rstn,
    input count_t counter,
    input logic   instr_complete,
    input logic   branch,
    input logic   address_ready,
    input logic   mem_write
);

    int fail_count = 0;  // Read by the testbench at the end

    // Strobes only on the last slice of a pass
    strobe_at_last: assert property (@(posedge clk) disable iff (!rstn)
        (instr_complete || branch || address_ready) |-> counter == LAST_COUNT)
        else begin
            $error("Strobe seen away from counter 7");
            fail_count++;
        end

    ready_in_write: assert property (@(posedge clk) disable iff (!rstn)
        address_ready |-> mem_write)
        else begin
            $error("address_ready without mem_write");
            fail_count++;
        end

    branch_completes: assert property (@(posedge clk) disable iff (!rstn)
        branch |-> instr_complete)
        else begin
            $error("branch without instr_complete");
            fail_count++;
        end

endmodule

// File: bench/tb_serial_cpu.sv
// Serial CPU testbench
`timescale 1ns/1ps

module tb_serial_cpu import nibble_pkg::*; ();

    logic    clk;
    logic    rstn;
    word_t   instr;
    word_t   pc;
    nibble_t data_out;
    addr_t   addr_out;
    logic    address_ready;
    logic    mem_write;
    logic    instr_complete;
    logic    branch;

    word_t   rom [0:1023];          // 4 KB program space indexed by pc bits 11 to 2
    word_t   mregs [0:NUM_REGS-1];  // Reference register model
    word_t   mpc;                   // pc seen by the instruction in execution
    word_t   nxt_pc;
    logic    nxt_taken;
    word_t   exp_data [$];
    addr_t   exp_addr [$];
    word_t   store_word;
    int      store_nibbles = 0;
    logic    stalled = 1'b0;
    string   cur_test;
    int      seed = 32'h5e3a_f949;
    int      err_count = 0;
    int      err_before = 0;
    int      tests_run = 0;
    int      tests_failed = 0;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    serial_cpu_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .instr          (instr),
        .pc             (pc),
        .data_out       (data_out),
        .addr_out       (addr_out),
        .address_ready  (address_ready),
        .mem_write      (mem_write),
        .instr_complete (instr_complete),
        .branch         (branch)
    );

    bind exec_core serial_cpu_checker u_checker (
        .clk            (clk),
        .rstn           (rstn),
        .counter        (counter),
        .instr_complete (instr_complete),
        .branch         (branch),
        .address_ready  (address_ready),
        .mem_write      (mem_write)
    );

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] op);
        return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
    endfunction

    function automatic word_t enc_r(input logic b30, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {1'b0, b30, 5'b00000, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, OP_ALU_REG};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic sub,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = sub ? a - b : a + b;
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b110:  r = a | b;
            3'b111:  r = a & b;
            default: r = '0;
        endcase
        return r;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++)
            rom[i] = {i[11:0], 5'd0, 3'b000, 5'd0, OP_ALU_IMM};  // addi x0 with the index
        instr = NOP_INSTR;
    end

    // ROM answers from pc
    always @(posedge clk) begin
        #2;
        instr = rom[pc[11:2]];
    end

    // Collect store nibbles and compare at address_ready
    always @(negedge clk) begin
        if (rstn && mem_write === 1'b1) begin
            store_word = {data_out, store_word[31:4]};
            store_nibbles++;
            if (address_ready === 1'b1) begin
                assert (store_nibbles == 8) else begin
                    $display("ERR %s store pass length: expected 8, actual %0d",
                             cur_test, store_nibbles);
                    err_count++;
                end
                store_nibbles = 0;
                if (exp_data.size() == 0) begin
                    $display("Store seen in %s with no store expected", cur_test);
                    err_count++;
                end else begin
                    assert (store_word === exp_data[0]) else begin
                        $display("ERR %s store data: expected %h, actual %h",
                                 cur_test, exp_data[0], store_word);
                        err_count++;
                    end
                    assert (addr_out === exp_addr[0]) else begin
                        $display("ERR %s store address: expected %h, actual %h",
                                 cur_test, exp_addr[0], addr_out);
                        err_count++;
                    end
                    void'(exp_data.pop_front());
                    void'(exp_addr.pop_front());
                end
            end
        end
    end

    // Place w at the fetch address and wait for the running instruction to finish
    task automatic issue(input word_t w);
        int n;
        rom[mpc[11:2]] = w;
        if (!stalled) begin
            @(negedge clk);
            n = 1;
            while (instr_complete !== 1'b1 && n < 40) begin
                @(negedge clk);
                n++;
            end
            if (instr_complete !== 1'b1) begin
                $display("Timeout in %s: no instruction completed in 40 cycles", cur_test);
                err_count++;
                stalled = 1'b1;  // Later instructions are skipped
            end else begin
                assert (branch === nxt_taken) else begin
                    $display("ERR %s branch: expected %b, actual %b",
                             cur_test, nxt_taken, branch);
                    err_count++;
                end
                @(posedge clk);
                #1;
                assert (pc === nxt_pc) else begin
                    $display("ERR %s pc: expected %h, actual %h", cur_test, nxt_pc, pc);
                    err_count++;
                end
                mpc       = nxt_pc;
                nxt_pc    = mpc + 32'd4;
                nxt_taken = 1'b0;
            end
        end
    endtask

    task automatic write_reg(input reg_addr_t rd, input word_t v);
        if (rd != '0)
            mregs[rd] = v;
    endtask

    task automatic alu_imm(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                           input logic [11:0] imm);
        issue(enc_i(imm, rs1, f3, rd, OP_ALU_IMM));
        write_reg(rd, alu_ref(f3, 1'b0, mregs[rs1], sext12(imm)));
    endtask

    task automatic alu_reg(input logic b30, input logic [2:0] f3, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2);
        issue(enc_r(b30, rs2, rs1, f3, rd));
        write_reg(rd, alu_ref(f3, b30, mregs[rs1], mregs[rs2]));
    endtask

    task automatic nop_instr();
        alu_imm(3'b000, 4'd0, 4'd0, 12'h000);
    endtask

    task automatic store(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
        word_t t;
        issue({imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], OP_STORE});
        t = mregs[rs1] + sext12(imm);
        exp_data.push_back(mregs[rs2]);
        exp_addr.push_back(t[31:4]);
    endtask

    task automatic upper(input logic [6:0] op, input reg_addr_t rd, input logic [19:0] imm);
        issue({imm, 1'b0, rd, op});
        write_reg(rd, (op == OP_AUIPC ? mpc : 32'd0) + {imm, 12'h000});
    endtask

    task automatic jump(input reg_addr_t rd, input logic [20:0] off);
        issue({off[20], off[10:1], off[11], off[19:12], 1'b0, rd, OP_JAL});
        nxt_pc    = (mpc + {{11{off[20]}}, off}) & ~32'hf;  // Targets land on 16 bytes
        nxt_taken = 1'b1;
        write_reg(rd, mpc + 32'd4);
    endtask

    task automatic jump_reg(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        issue(enc_i(imm, rs1, 3'b000, rd, OP_JALR));
        nxt_pc    = (mregs[rs1] + sext12(imm)) & ~32'hf;
        nxt_taken = 1'b1;
        write_reg(rd, mpc + 32'd4);
    endtask

    task automatic cond_branch(input logic [2:0] f3, input reg_addr_t rs1,
                               input reg_addr_t rs2, input logic [12:0] off);
        logic cond;
        issue({off[12], off[10:5], 1'b0, rs2, 1'b0, rs1, f3, off[4:1], off[11], OP_BRANCH});
        case (f3[2:1])
            2'b00:   cond = mregs[rs1] == mregs[rs2];
            2'b10:   cond = $signed(mregs[rs1]) < $signed(mregs[rs2]);
            2'b11:   cond = mregs[rs1] < mregs[rs2];
            default: cond = 1'b0;
        endcase
        if (f3[0])
            cond = !cond;  // BNE, BGE, BGEU
        if (cond) begin
            nxt_pc    = (mpc + {{19{off[12]}}, off}) & ~32'hf;
            nxt_taken = 1'b1;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        err_before = err_count;
    endtask

    task automatic end_test();
        nop_instr();  // Lets the last store pass finish
        if (exp_data.size() != 0) begin
            $display("%s: %0d expected stores never appeared", cur_test, exp_data.size());
            err_count++;
            exp_data.delete();
            exp_addr.delete();
        end
        tests_run++;
        if (err_count > err_before) begin
            tests_failed++;
            $display("%s: FAIL with %0d errors", cur_test, err_count - err_before);
        end else begin
            $display("%s: PASS", cur_test);
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        assert (pc === 32'd0) else begin
            $display("ERR %s pc: expected %h, actual %h", cur_test, 32'd0, pc);
            err_count++;
        end
        assert ({instr_complete, branch, address_ready, mem_write} === 4'b0000) else begin
            $display("ERR %s control outputs: expected %b, actual %b", cur_test, 4'b0000,
                     {instr_complete, branch, address_ready, mem_write});
            err_count++;
        end
        nop_instr();  // pc must reach 4 here
        end_test();
    endtask

    task automatic test_arith();
        int r;
        logic [11:0] i1;
        logic [11:0] i2;
        begin_test("arith");
        for (int k = 0; k < 3; k++) begin
            r  = $random(seed);
            i1 = r[11:0];
            r  = $random(seed);
            i2 = r[11:0];
            alu_imm(3'b000, 4'd1, 4'd0, i1);
            alu_imm(3'b000, 4'd2, 4'd0, i2);
            alu_reg(1'b0, 3'b000, 4'd3, 4'd1, 4'd2);
            alu_reg(1'b1, 3'b000, 4'd4, 4'd1, 4'd2);
            alu_reg(1'b0, 3'b111, 4'd5, 4'd1, 4'd2);
            alu_reg(1'b0, 3'b110, 4'd6, 4'd1, 4'd2);
            alu_reg(1'b0, 3'b100, 4'd7, 4'd1, 4'd2);
            alu_imm(3'b111, 4'd8, 4'd3, i2);
            alu_imm(3'b110, 4'd9, 4'd4, i1);
            alu_imm(3'b100, 4'd10, 4'd5, i2);
            alu_imm(3'b000, 4'd0, 4'd1, i1);  // x0 must ignore this
            for (int j = 0; j <= 10; j++)
                store(reg_addr_t'(j), 4'd0, 12'(4 * j));
        end
        end_test();
    endtask

    task automatic test_compare();
        int r;
        begin_test("compare");
        r = $random(seed);
        upper(OP_LUI, 4'd3, r[19:0]);
        r = $random(seed);
        alu_imm(3'b000, 4'd3, 4'd3, r[11:0]);
        alu_imm(3'b000, 4'd1, 4'd0, 12'hffb);  // -5
        alu_imm(3'b000, 4'd2, 4'd0, 12'h003);
        alu_reg(1'b0, 3'b010, 4'd4, 4'd1, 4'd2);
        alu_reg(1'b0, 3'b011, 4'd5, 4'd1, 4'd2);
        alu_reg(1'b0, 3'b010, 4'd6, 4'd2, 4'd1);
        alu_reg(1'b0, 3'b011, 4'd7, 4'd2, 4'd1);
        alu_reg(1'b0, 3'b010, 4'd8, 4'd3, 4'd1);
        r = $random(seed);
        alu_imm(3'b010, 4'd9, 4'd1, r[11:0]);
        alu_imm(3'b011, 4'd10, 4'd2, 12'hfff);
        alu_imm(3'b010, 4'd11, 4'd2, 12'hffe);
        for (int j = 4; j <= 11; j++)
            store(reg_addr_t'(j), 4'd0, 12'(4 * j));
        end_test();
    endtask

    task automatic test_upper();
        int r;
        begin_test("upper");
        r = $random(seed);
        upper(OP_LUI, 4'd1, r[19:0]);
        r = $random(seed);
        upper(OP_AUIPC, 4'd2, r[19:0]);
        upper(OP_AUIPC, 4'd3, 20'h00000);
        store(4'd1, 4'd0, 12'h000);
        store(4'd2, 4'd0, 12'h004);
        store(4'd3, 4'd0, 12'h008);
        r = $random(seed);
        store(4'd2, 4'd1, r[11:0]);
        r = $random(seed);
        store(4'd1, 4'd2, r[11:0]);
        end_test();
    endtask

    task automatic test_flow();
        logic [2:0] kinds [6];
        begin_test("flow");
        kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        alu_imm(3'b000, 4'd3, 4'd0, 12'h200);
        jump(4'd1, 21'h000020);
        nop_instr();  // Runs before the target
        store(4'd1, 4'd0, 12'h000);
        jump_reg(4'd2, 4'd3, 12'h010);
        nop_instr();
        store(4'd2, 4'd0, 12'h004);
        jump(4'd4, 21'h1fffc0);  // Backward
        nop_instr();
        store(4'd4, 4'd0, 12'h008);
        alu_imm(3'b000, 4'd5, 4'd0, 12'hffb);
        alu_imm(3'b000, 4'd6, 4'd0, 12'h003);
        alu_imm(3'b000, 4'd7, 4'd0, 12'h003);
        for (int k = 0; k < 6; k++) begin
            cond_branch(kinds[k], 4'd5, 4'd6, 13'h0020);
            nop_instr();
            cond_branch(kinds[k], 4'd6, 4'd7, 13'h0030);
            nop_instr();
            cond_branch(kinds[k], 4'd6, 4'd5, 13'h0040);
            nop_instr();
        end
        end_test();
    endtask

    initial begin
        int n;
        int chk_fails;
        mpc       = '0;
        nxt_pc    = 32'd4;  // NOP runs first after reset
        nxt_taken = 1'b0;
        for (int i = 0; i < NUM_REGS; i++)
            mregs[i] = '0;
        n = 0;
        while (rstn !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("Reset was never released");
            $display("Test failed");
            $finish;
        end else begin
            #1;
            test_reset();
            test_arith();
            test_compare();
            test_upper();
            test_flow();
            chk_fails = UUT.u_core.u_checker.fail_count;
            $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                     tests_run, tests_failed, err_count, chk_fails);
            if (err_count == 0 && chk_fails == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
            $finish;
        end
    end

endmodule

// File: src.f
logic/nibble_pkg.sv
logic/decoded_if.sv
logic/nibble_regfile.sv
logic/nibble_alu.sv
logic/issue_stage.sv
logic/exec_core.sv
logic/serial_cpu_top.sv
bench/tb_clock.sv
bench/serial_cpu_checker.sv
bench/tb_serial_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the serial CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_serial_cpu \
    -f src.f -o sim_serial_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/sim_serial_cpu +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
